// File: Makefile
# Verilator build for the stream CDC testbench.

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       := stream_cdc_tb
FILELIST  := stream_cdc_top.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the exit code of the binary is not used.
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: stream_cdc_top.f
verilog/cdc_fifo_pkg.sv
verilog/gray_ptr_sync.sv
verilog/dual_port_ram.sv
verilog/async_fifo.sv
verilog/fifo_read_stage.sv
verilog/stream_cdc_top.sv
testbench/stream_cdc_tb.sv

// File: testbench/stream_cdc_tb.sv
`timescale 1ns/1ps

module stream_cdc_tb;

  localparam int DATA_WIDTH    = cdc_fifo_pkg::DEF_DATA_WIDTH;
  localparam int FIFO_DEPTH    = cdc_fifo_pkg::DEF_FIFO_DEPTH;
  localparam int CAPACITY      = FIFO_DEPTH + 2;  // fifo words plus the two-entry read buffer.
  localparam int RD_PERIOD     = 10;
  localparam int WR_PERIOD     = 14;
  localparam int RST_CYCLES    = 3;
  localparam int HOLD_CYCLES   = 50;
  localparam int SETTLE_CYCLES = 16;
  localparam int N_RANDOM      = 300;

  // phase lengths counted in cycles of wr_clk, which is the slower clock.
  localparam int TEST_CYCLES = RST_CYCLES + CAPACITY + HOLD_CYCLES + 4 * CAPACITY +
                               2 * SETTLE_CYCLES + 4 * N_RANDOM;
  localparam int WATCHDOG_NS = TEST_CYCLES * WR_PERIOD * 4;

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_valid;
  logic                  wr_ready;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  out_valid;
  logic                  out_ready;
  logic [DATA_WIDTH-1:0] out_data;
  logic                  afull;
  logic                  aempty;

  integer                seed = 32'h76f3_cdcf;
  logic [DATA_WIDTH-1:0] expected_q [$];  // words accepted and not yet seen at the output.
  int                    accepted_cnt = 0;
  int                    received_cnt = 0;
  int                    error_cnt = 0;
  logic                  wr_taken = 1'b0;  // handshake on the last wr_clk edge.

  stream_cdc_top stream_cdc_top_inst (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .afull     (afull),
    .aempty    (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  end

  task automatic report_error(input string msg);
    error_cnt++;
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic expect_value(input string name, input int got, input int exp);
    assert (got == exp)
      else report_error($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // true with a chance of pct percent.
  function automatic logic chance(input int pct);
    int r;
    r = $random(seed);
    return ((r & 32'h7fff_ffff) % 100) < pct;
  endfunction

  initial begin
    #(WATCHDOG_NS);
    report_error("watchdog expired before the test sequence completed");
  end

  // every accepted word goes into the scoreboard.
  always @(posedge wr_clk) begin
    wr_taken = wr_rst_n && wr_valid && wr_ready;
    if (wr_taken) begin
      expected_q.push_back(wr_data);
      accepted_cnt++;
    end
  end

  // the output must match the oldest word still queued.
  always @(posedge rd_clk) begin
    if (rd_rst_n && out_valid && out_ready) begin
      assert (expected_q.size() > 0)
        else report_error("output handshake with no word left in the scoreboard");
      assert (out_data == expected_q[0])
        else report_error($sformatf("MISMATCH out_data: got 0x%h expected 0x%h",
                                    out_data, expected_q[0]));
      void'(expected_q.pop_front());
      received_cnt++;
    end
  end

  hold_check: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else report_error("out_valid or out_data changed while out_ready was low");

  initial begin
    int low_run;
    int target;

    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    wr_valid  = 1'b0;
    wr_data   = '0;
    out_ready = 1'b0;

    fork
      begin
        repeat (RST_CYCLES) @(posedge wr_clk);
        @(negedge wr_clk);
        wr_rst_n = 1'b1;
      end
      begin
        repeat (RST_CYCLES) @(posedge rd_clk);
        @(negedge rd_clk);
        rd_rst_n = 1'b1;
      end
    join

    // reset state.
    @(negedge rd_clk);
    expect_value("out_valid", int'(out_valid), 0);
    expect_value("aempty", int'(aempty), 1);
    @(negedge wr_clk);
    expect_value("afull", int'(afull), 0);
    expect_value("wr_ready", int'(wr_ready), 1);

    // out_ready stays low and writes go on until wr_ready sticks low.
    wr_valid = 1'b1;
    wr_data  = DATA_WIDTH'($random(seed));
    low_run  = 0;
    while (low_run < HOLD_CYCLES) begin
      @(posedge wr_clk);
      low_run = wr_ready ? 0 : low_run + 1;
      @(negedge wr_clk);
      if (wr_taken) begin
        wr_data = DATA_WIDTH'($random(seed));
      end
    end
    wr_valid = 1'b0;
    expect_value("accepted words", accepted_cnt, CAPACITY);
    expect_value("afull", int'(afull), 1);
    @(negedge rd_clk);
    expect_value("aempty", int'(aempty), 0);  // the fifo itself holds FIFO_DEPTH words.

    // drain everything that was held.
    @(negedge rd_clk);
    out_ready = 1'b1;
    while (expected_q.size() != 0) begin
      @(posedge rd_clk);
    end
    repeat (SETTLE_CYCLES) @(negedge rd_clk);
    expect_value("out_valid", int'(out_valid), 0);
    expect_value("aempty", int'(aempty), 1);
    @(negedge wr_clk);
    expect_value("wr_ready", int'(wr_ready), 1);
    expect_value("afull", int'(afull), 0);

    // random traffic on both sides.
    target = accepted_cnt + N_RANDOM;
    fork
      begin
        while (accepted_cnt < target) begin
          @(negedge wr_clk);
          if (accepted_cnt >= target) begin
            wr_valid = 1'b0;
          end else if (wr_taken || !wr_valid) begin
            wr_valid = chance(60);
            wr_data  = DATA_WIDTH'($random(seed));
          end
        end
        wr_valid = 1'b0;
      end
      begin
        while (received_cnt < target) begin
          @(negedge rd_clk);
          out_ready = chance(50);
        end
        out_ready = 1'b1;
      end
    join

    repeat (SETTLE_CYCLES) @(negedge rd_clk);
    expect_value("words left in scoreboard", expected_q.size(), 0);
    expect_value("received words", received_cnt, accepted_cnt);
    expect_value("out_valid", int'(out_valid), 0);
    expect_value("aempty", int'(aempty), 1);

    if (error_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/async_fifo.sv
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 2,
  parameter int SYNC_STAGES = 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic                  full,
  output logic                  afull,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic                  rd_ack,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  empty,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int PW         = cdc_fifo_pkg::MAX_PTR_WIDTH;
  localparam int PAD        = PW - ADDR_WIDTH - 1;

  logic                wr_ok;
  logic                rd_ok;

  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray;
  logic [ADDR_WIDTH:0] rd_gray_nxt;

  logic [ADDR_WIDTH:0] rd_bin_sync;   // read pointer seen in wr_clk.
  logic [ADDR_WIDTH:0] wr_bin_sync;   // write pointer seen in rd_clk.
  logic [ADDR_WIDTH:0] rd_gray_sync;
  logic [ADDR_WIDTH:0] wr_gray_sync;

  logic [PW-1:0]       wr_gray_w;
  logic [PW-1:0]       rd_gray_w;
  logic [PW-1:0]       rd_gray_sync_w;
  logic [PW-1:0]       wr_gray_sync_w;

  logic [ADDR_WIDTH:0] wr_used;
  logic [ADDR_WIDTH:0] rd_used;

  assign wr_ok  = wr_en && !full;
  assign rd_ok  = rd_en && !empty;
  assign rd_ack = rd_ok;

  dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) ram_inst (
    .wr_clk  (wr_clk),
    .wr_en   (wr_ok),
    .wr_addr (wr_bin[ADDR_WIDTH-1:0]),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_ok),
    .rd_addr (rd_bin[ADDR_WIDTH-1:0]),
    .rd_data (rd_data)
  );

  gray_ptr_sync #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) wr2rd_sync_inst (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_bin_sync)
  );

  gray_ptr_sync #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .SYNC_STAGES (SYNC_STAGES)
  ) rd2wr_sync_inst (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_bin_sync)
  );

  assign wr_bin_nxt = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_ok};
  assign rd_bin_nxt = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_ok};

  assign wr_gray_w      = cdc_fifo_pkg::bin2gray({{PAD{1'b0}}, wr_bin_nxt});
  assign rd_gray_w      = cdc_fifo_pkg::bin2gray({{PAD{1'b0}}, rd_bin_nxt});
  assign rd_gray_sync_w = cdc_fifo_pkg::bin2gray({{PAD{1'b0}}, rd_bin_sync});
  assign wr_gray_sync_w = cdc_fifo_pkg::bin2gray({{PAD{1'b0}}, wr_bin_sync});

  assign wr_gray_nxt  = wr_gray_w[ADDR_WIDTH:0];
  assign rd_gray_nxt  = rd_gray_w[ADDR_WIDTH:0];
  assign rd_gray_sync = rd_gray_sync_w[ADDR_WIDTH:0];  // back to gray for the flag compare.
  assign wr_gray_sync = wr_gray_sync_w[ADDR_WIDTH:0];

  assign wr_used = wr_bin_nxt - rd_bin_sync;
  assign rd_used = wr_bin_sync - rd_bin_nxt;

  // write domain.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      // full when the writer has lapped the reader: top two gray bits differ.
      full    <= (wr_gray_nxt == {~rd_gray_sync[ADDR_WIDTH:ADDR_WIDTH-1],
                                  rd_gray_sync[ADDR_WIDTH-2:0]});
      afull   <= (wr_used >= FIFO_AFULL);
    end
  end

  // read domain.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
      empty   <= (rd_gray_nxt == wr_gray_sync);
      aempty  <= (rd_used <= FIFO_AEMPTY);  // pessimistic, the sync lags the writer.
    end
  end

endmodule

// File: verilog/cdc_fifo_pkg.sv
package cdc_fifo_pkg;

  parameter int DEF_DATA_WIDTH  = 8;
  parameter int DEF_FIFO_DEPTH  = 16;  // must stay a power of two.
  parameter int DEF_SYNC_STAGES = 2;

  // widest pointer the conversions handle; callers zero-extend and slice.
  parameter int MAX_PTR_WIDTH = 16;

  function automatic logic [MAX_PTR_WIDTH-1:0] bin2gray(
    input logic [MAX_PTR_WIDTH-1:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [MAX_PTR_WIDTH-1:0] gray2bin(
    input logic [MAX_PTR_WIDTH-1:0] gray
  );
    logic [MAX_PTR_WIDTH-1:0] bin;
    bin[MAX_PTR_WIDTH-1] = gray[MAX_PTR_WIDTH-1];
    for (int i = MAX_PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];  // running xor from the msb down.
    end
    return bin;
  endfunction

endpackage

// File: verilog/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, data shows one rd_clk cycle after rd_en.
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: verilog/fifo_read_stage.sv
`timescale 1ns/1ps

module fifo_read_stage #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  empty,
  output logic                  rd_en,
  input  logic                  rd_ack,
  input  logic [DATA_WIDTH-1:0] rd_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [DATA_WIDTH-1:0] out_data
);

  logic [DATA_WIDTH-1:0] buf_q [2];
  logic                  wr_ptr;
  logic                  rd_ptr;
  logic [1:0]            count;
  logic                  ack_q;     // read in flight, data on rd_data this cycle.
  logic                  pop;
  logic [1:0]            pending;

  assign pop     = out_valid && out_ready;
  // words held or in flight once this cycle's pop is taken out.
  assign pending = count + {1'b0, ack_q} - {1'b0, pop};
  assign rd_en   = (pending < 2'd2) && !empty;

  assign out_valid = (count != 2'd0);
  assign out_data  = buf_q[rd_ptr];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      ack_q  <= 1'b0;
      count  <= 2'd0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      ack_q <= rd_ack;
      count <= pending;
      if (ack_q) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  // a push never lands on the head while out_valid is up.
  always_ff @(posedge rd_clk) begin
    if (ack_q) begin
      buf_q[wr_ptr] <= rd_data;
    end
  end

endmodule

// File: verilog/gray_ptr_sync.sv
`timescale 1ns/1ps

module gray_ptr_sync #(
  parameter int ADDR_WIDTH  = 4,
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [ADDR_WIDTH:0] gray_in,
  output logic [ADDR_WIDTH:0] bin_out
);

  localparam int PW = cdc_fifo_pkg::MAX_PTR_WIDTH;

  logic [ADDR_WIDTH:0] sync_q [SYNC_STAGES];
  logic [PW-1:0]       bin_w;

  // only one bit of gray_in moves per source edge, so the chain never sees a torn value.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= gray_in;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign bin_w   = cdc_fifo_pkg::gray2bin({{(PW-ADDR_WIDTH-1){1'b0}}, sync_q[SYNC_STAGES-1]});
  assign bin_out = bin_w[ADDR_WIDTH:0];

endmodule

// File: verilog/stream_cdc_top.sv
`timescale 1ns/1ps

module stream_cdc_top #(
  parameter int DATA_WIDTH  = cdc_fifo_pkg::DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = cdc_fifo_pkg::DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 2,
  parameter int SYNC_STAGES = cdc_fifo_pkg::DEF_SYNC_STAGES
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_valid,
  output logic                  wr_ready,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  afull,
  output logic                  aempty
);

  logic                  full;
  logic                  empty;
  logic                  rd_en;
  logic                  rd_ack;
  logic [DATA_WIDTH-1:0] rd_data;

  assign wr_ready = !full;  // full is a register, so ready is too.

  // wr_valid goes straight in; the fifo drops it when full.
  async_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AFULL  (FIFO_AFULL),
    .FIFO_AEMPTY (FIFO_AEMPTY),
    .SYNC_STAGES (SYNC_STAGES)
  ) fifo_inst (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_valid),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_ack   (rd_ack),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  fifo_read_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) read_stage_inst (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .empty     (empty),
    .rd_en     (rd_en),
    .rd_ack    (rd_ack),
    .rd_data   (rd_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule
